//--- Makefile
# Verilator build and run for the shared multi-FIFO testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_shared_fifo
FILELIST  = compile.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SIMARGS   = +verilator+error+limit+1000
SOURCES   = $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+design
design/shared_fifo_pkg.sv
design/shared_fifo_push_ctrl.sv
design/shared_fifo_ram.sv
design/shared_fifo_pop_ctrl.sv
design/shared_fifo_read_arb.sv
design/shared_fifo_top.sv
verif/tb_clock_gen.sv
verif/shared_fifo_properties.sv
verif/tb_shared_fifo.sv

//--- design/shared_fifo_macros.svh
/*
  Size settings for the shared multi-FIFO.
  Included by the package, every RTL module and the testbench files.
  Change the sizes here and rebuild, nothing else needs editing.
*/
`ifndef SHARED_FIFO_MACROS_SVH
`define SHARED_FIFO_MACROS_SVH

// Number of logical FIFOs sharing the RAM
`define SFIFO_NUM_FIFOS 4

// Entries in the shared RAM
`define SFIFO_DEPTH 16

// Payload width in bits
`define SFIFO_WIDTH 8

// Staging entries in front of each pop port
`define SFIFO_STAGING_DEPTH 2

`endif

//--- design/shared_fifo_pkg.sv
/*
  Shared types for the multi-FIFO.
  All widths derive from the size macros, so a module imports this
  package and includes the macros header to see both.
*/
`include "shared_fifo_macros.svh"

package shared_fifo_pkg;

  // Address into the shared RAM
  typedef logic [$clog2(`SFIFO_DEPTH)-1:0] addr_t;

  // Logical FIFO number
  typedef logic [$clog2(`SFIFO_NUM_FIFOS)-1:0] fifo_id_t;

  // One payload word
  typedef logic [`SFIFO_WIDTH-1:0] data_t;

  // Occupancy from 0 up to the full RAM depth
  typedef logic [$clog2(`SFIFO_DEPTH):0] count_t;

endpackage

//--- design/shared_fifo_pop_ctrl.sv
/*
  Pop side of one logical FIFO.
  Tracks how many entries of this FIFO sit in the shared RAM, requests
  reads through the arbiter and keeps a small staging buffer in front
  of the pop port. One instance per FIFO, built in a generate loop.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module shared_fifo_pop_ctrl
  import shared_fifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  addr_t cfg_base,
  input  addr_t cfg_bound,

  input  logic  push_inc,
  output logic  fifo_full,

  output logic  rd_req,
  output addr_t rd_addr,
  input  logic  rd_grant,
  input  logic  rd_data_valid,
  input  data_t rd_data,

  input  logic  pop_ready,
  output logic  pop_valid,
  output data_t pop_data,
  output logic  pop_empty
);

  localparam int STG     = `SFIFO_STAGING_DEPTH;
  localparam int STG_PW  = (STG > 1) ? $clog2(STG) : 1;
  localparam int STG_CW  = $clog2(STG + 1);

  count_t              ram_count;
  count_t              capacity;
  addr_t               rd_ptr;

  data_t               stg_mem [STG];
  logic [STG_PW-1:0]   stg_wr_ptr;
  logic [STG_PW-1:0]   stg_rd_ptr;
  logic [STG_CW-1:0]   stg_count;
  logic [STG_CW-1:0]   inflight;
  logic                pop_xfer;

  assign capacity  = count_t'({1'b0, cfg_bound}) - count_t'({1'b0, cfg_base}) + 1'b1;
  assign fifo_full = (ram_count == capacity);

  // Only ask for data that is sure to find room in staging
  assign rd_req  = (ram_count != '0) && ((int'(stg_count) + int'(inflight)) < STG);
  assign rd_addr = rd_ptr;

  assign pop_xfer  = pop_valid && pop_ready;
  assign pop_valid = (stg_count != '0);
  assign pop_data  = stg_mem[stg_rd_ptr];
  // An item in flight from the RAM still counts as content
  assign pop_empty = (ram_count == '0) && (stg_count == '0) && (inflight == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      ram_count <= '0;
      rd_ptr    <= cfg_base;
    end else begin
      case ({push_inc, rd_grant})
        2'b10:   ram_count <= ram_count + 1'b1;
        2'b01:   ram_count <= ram_count - 1'b1;
        default: ram_count <= ram_count;
      endcase
      if (rd_grant) begin
        rd_ptr <= (rd_ptr == cfg_bound) ? cfg_base : rd_ptr + 1'b1;
      end
    end
  end

  // Reads granted but not yet returned
  always_ff @(posedge clk) begin
    if (rst) begin
      inflight <= '0;
    end else begin
      case ({rd_grant, rd_data_valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stg_wr_ptr <= '0;
      stg_rd_ptr <= '0;
      stg_count  <= '0;
    end else begin
      if (rd_data_valid) begin
        stg_wr_ptr <= (int'(stg_wr_ptr) == STG - 1) ? '0 : stg_wr_ptr + 1'b1;
      end
      if (pop_xfer) begin
        stg_rd_ptr <= (int'(stg_rd_ptr) == STG - 1) ? '0 : stg_rd_ptr + 1'b1;
      end
      case ({rd_data_valid, pop_xfer})
        2'b10:   stg_count <= stg_count + 1'b1;
        2'b01:   stg_count <= stg_count - 1'b1;
        default: stg_count <= stg_count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_data_valid) begin
      stg_mem[stg_wr_ptr] <= rd_data;
    end
  end

endmodule

//--- design/shared_fifo_push_ctrl.sv
/*
  Push side of the shared multi-FIFO.
  Checks the region configuration, holds one write pointer per FIFO
  and writes accepted items straight into the shared RAM.
  push_inc tells the owning pop controller that an entry was added.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module shared_fifo_push_ctrl
  import shared_fifo_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,

  input  addr_t    [`SFIFO_NUM_FIFOS-1:0]     config_base,
  input  addr_t    [`SFIFO_NUM_FIFOS-1:0]     config_bound,
  output logic                                config_error,

  input  logic                                push_valid,
  input  data_t                               push_data,
  input  fifo_id_t                            push_fifo_id,
  output logic                                push_ready,

  input  logic     [`SFIFO_NUM_FIFOS-1:0]     fifo_full,
  output logic     [`SFIFO_NUM_FIFOS-1:0]     push_inc,

  output logic                                ram_wr_en,
  output addr_t                               ram_wr_addr,
  output data_t                               ram_wr_data
);

  localparam int NUM = `SFIFO_NUM_FIFOS;

  logic              cfg_bad;
  logic              accept_en;
  addr_t [NUM-1:0]   wr_ptr;

  // Regions must be non-empty and placed in ascending, disjoint order
  always_comb begin
    cfg_bad = 1'b0;
    for (int i = 0; i < NUM; i++) begin
      if (config_base[i] > config_bound[i]) begin
        cfg_bad = 1'b1;
      end
    end
    for (int i = 0; i < NUM - 1; i++) begin
      if (config_base[i+1] <= config_bound[i]) begin
        cfg_bad = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      config_error <= 1'b0;
      accept_en    <= 1'b0;
    end else begin
      config_error <= cfg_bad;
      accept_en    <= 1'b1;
    end
  end

  // Stays low through reset and the first edge out of it
  assign push_ready  = accept_en && !config_error && !fifo_full[push_fifo_id];

  assign ram_wr_en   = push_valid && push_ready;
  assign ram_wr_addr = wr_ptr[push_fifo_id];
  assign ram_wr_data = push_data;

  always_comb begin
    push_inc = '0;
    if (ram_wr_en) begin
      push_inc[push_fifo_id] = 1'b1;
    end
  end

  // Write pointers wrap from bound back to base of their own region
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM; i++) begin
        wr_ptr[i] <= config_base[i];
      end
    end else begin
      for (int i = 0; i < NUM; i++) begin
        if (push_inc[i]) begin
          if (wr_ptr[i] == config_bound[i]) begin
            wr_ptr[i] <= config_base[i];
          end else begin
            wr_ptr[i] <= wr_ptr[i] + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- design/shared_fifo_ram.sv
/*
  Shared storage for all logical FIFOs.
  One write port and one read port with a registered output, so read
  data appears the cycle after ram_rd_en. A same-address write and read
  in one cycle returns the old contents.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module shared_fifo_ram
  import shared_fifo_pkg::*;
(
  input  logic  clk,

  input  logic  ram_wr_en,
  input  addr_t ram_wr_addr,
  input  data_t ram_wr_data,

  input  logic  ram_rd_en,
  input  addr_t ram_rd_addr,
  output data_t ram_rd_data
);

  data_t mem [`SFIFO_DEPTH];

  always_ff @(posedge clk) begin
    if (ram_wr_en) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  // Output register holds its value when no read is issued
  always_ff @(posedge clk) begin
    if (ram_rd_en) begin
      ram_rd_data <= mem[ram_rd_addr];
    end
  end

endmodule

//--- design/shared_fifo_read_arb.sv
/*
  Read arbiter for the shared RAM.
  Grants one pending FIFO read per cycle in round-robin order and
  routes the RAM output back to that FIFO one cycle later.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module shared_fifo_read_arb
  import shared_fifo_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,

  input  logic  [`SFIFO_NUM_FIFOS-1:0]    rd_req,
  input  addr_t [`SFIFO_NUM_FIFOS-1:0]    rd_addr,
  output logic  [`SFIFO_NUM_FIFOS-1:0]    rd_grant,

  output logic                            ram_rd_en,
  output addr_t                           ram_rd_addr,
  input  data_t                           ram_rd_data,

  output logic  [`SFIFO_NUM_FIFOS-1:0]    rd_data_valid,
  output data_t                           rd_data
);

  localparam int NUM = `SFIFO_NUM_FIFOS;

  fifo_id_t rr_ptr;
  fifo_id_t grant_id;
  logic     grant_any;
  fifo_id_t ret_id;
  logic     ret_pending;

  // Search starts at the FIFO after the last winner
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_id  = rr_ptr;
    for (int k = 0; k < NUM; k++) begin
      idx = (int'(rr_ptr) + k) % NUM;
      if (!grant_any && rd_req[idx]) begin
        grant_any = 1'b1;
        grant_id  = fifo_id_t'(idx);
      end
    end
  end

  always_comb begin
    rd_grant = '0;
    if (grant_any) begin
      rd_grant[grant_id] = 1'b1;
    end
  end

  assign ram_rd_en   = grant_any;
  assign ram_rd_addr = rd_addr[grant_id];

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr      <= '0;
      ret_pending <= 1'b0;
      ret_id      <= '0;
    end else begin
      ret_pending <= grant_any;
      if (grant_any) begin
        ret_id <= grant_id;
        rr_ptr <= (int'(grant_id) == NUM - 1) ? '0 : grant_id + 1'b1;
      end
    end
  end

  always_comb begin
    rd_data_valid = '0;
    if (ret_pending) begin
      rd_data_valid[ret_id] = 1'b1;
    end
  end

  assign rd_data = ram_rd_data;

endmodule

//--- design/shared_fifo_top.sv
/*
  Top level of the shared pseudo-static multi-FIFO.
  One push port feeds several logical FIFOs that live in fixed regions
  of a single RAM, each with its own pop port. Set config_base and
  config_bound while rst is high and keep them stable afterwards.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module shared_fifo_top
  import shared_fifo_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,

  input  addr_t [`SFIFO_NUM_FIFOS-1:0]    config_base,
  input  addr_t [`SFIFO_NUM_FIFOS-1:0]    config_bound,
  output logic                            config_error,

  input  logic                            push_valid,
  output logic                            push_ready,
  input  data_t                           push_data,
  input  fifo_id_t                        push_fifo_id,
  output logic  [`SFIFO_NUM_FIFOS-1:0]    push_full,

  output logic  [`SFIFO_NUM_FIFOS-1:0]    pop_valid,
  input  logic  [`SFIFO_NUM_FIFOS-1:0]    pop_ready,
  output data_t [`SFIFO_NUM_FIFOS-1:0]    pop_data,
  output logic  [`SFIFO_NUM_FIFOS-1:0]    pop_empty
);

  logic  [`SFIFO_NUM_FIFOS-1:0] push_inc;
  logic  [`SFIFO_NUM_FIFOS-1:0] rd_req;
  addr_t [`SFIFO_NUM_FIFOS-1:0] rd_addr;
  logic  [`SFIFO_NUM_FIFOS-1:0] rd_grant;
  logic  [`SFIFO_NUM_FIFOS-1:0] rd_data_valid;
  data_t                        rd_data;

  logic  ram_wr_en;
  addr_t ram_wr_addr;
  data_t ram_wr_data;
  logic  ram_rd_en;
  addr_t ram_rd_addr;
  data_t ram_rd_data;

  shared_fifo_push_ctrl u_push (
    .clk          (clk),
    .rst          (rst),
    .config_base  (config_base),
    .config_bound (config_bound),
    .config_error (config_error),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_fifo_id (push_fifo_id),
    .push_ready   (push_ready),
    .fifo_full    (push_full),
    .push_inc     (push_inc),
    .ram_wr_en    (ram_wr_en),
    .ram_wr_addr  (ram_wr_addr),
    .ram_wr_data  (ram_wr_data)
  );

  shared_fifo_ram u_ram (
    .clk         (clk),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .ram_wr_data (ram_wr_data),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data)
  );

  shared_fifo_read_arb u_arb (
    .clk           (clk),
    .rst           (rst),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_grant      (rd_grant),
    .ram_rd_en     (ram_rd_en),
    .ram_rd_addr   (ram_rd_addr),
    .ram_rd_data   (ram_rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  // One pop controller per logical FIFO
  for (genvar i = 0; i < `SFIFO_NUM_FIFOS; i++) begin : gen_fifo
    shared_fifo_pop_ctrl u_pop (
      .clk           (clk),
      .rst           (rst),
      .cfg_base      (config_base[i]),
      .cfg_bound     (config_bound[i]),
      .push_inc      (push_inc[i]),
      .fifo_full     (push_full[i]),
      .rd_req        (rd_req[i]),
      .rd_addr       (rd_addr[i]),
      .rd_grant      (rd_grant[i]),
      .rd_data_valid (rd_data_valid[i]),
      .rd_data       (rd_data),
      .pop_ready     (pop_ready[i]),
      .pop_valid     (pop_valid[i]),
      .pop_data      (pop_data[i]),
      .pop_empty     (pop_empty[i])
    );
  end

endmodule

//--- verif/shared_fifo_properties.sv
/*
  Concurrent checks for the shared multi-FIFO, bound to shared_fifo_top.
  Covers the configuration rule, pop stability under stall, push id range
  and forward progress of every non-empty FIFO.
  assert_fails counts failures so the testbench can read it.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module shared_fifo_properties
  import shared_fifo_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  addr_t [`SFIFO_NUM_FIFOS-1:0]    config_base,
  input  addr_t [`SFIFO_NUM_FIFOS-1:0]    config_bound,
  input  logic                            config_error,
  input  logic                            push_valid,
  input  logic                            push_ready,
  input  fifo_id_t                        push_fifo_id,
  input  logic  [`SFIFO_NUM_FIFOS-1:0]    pop_valid,
  input  logic  [`SFIFO_NUM_FIFOS-1:0]    pop_ready,
  input  data_t [`SFIFO_NUM_FIFOS-1:0]    pop_data,
  input  logic  [`SFIFO_NUM_FIFOS-1:0]    pop_empty
);

  localparam int NUM   = `SFIFO_NUM_FIFOS;
  localparam int LIMIT = 200;

  int unsigned assert_fails = 0;
  logic        cfg_illegal;

  // Empty region or regions not strictly ascending
  always_comb begin
    cfg_illegal = 1'b0;
    for (int i = 0; i < NUM; i++) begin
      if (config_base[i] > config_bound[i]) cfg_illegal = 1'b1;
      if (i < NUM - 1 && config_base[i+1] <= config_bound[i]) cfg_illegal = 1'b1;
    end
  end

  config_rule_chk: assert property (@(posedge clk) disable iff (rst)
    config_error == ($past(rst) ? 1'b0 : $past(cfg_illegal)))
    else begin
      assert_fails++;
      $error("config_error does not follow the region rule");
    end

  config_block_chk: assert property (@(posedge clk) disable iff (rst)
    config_error |-> !push_ready)
    else begin
      assert_fails++;
      $error("push_ready high while config_error is set");
    end

  push_id_chk: assert property (@(posedge clk) disable iff (rst)
    push_valid |-> !$isunknown(push_fifo_id) && int'(push_fifo_id) < NUM)
    else begin
      assert_fails++;
      $error("push_fifo_id out of range");
    end

  for (genvar i = 0; i < NUM; i++) begin : gen_chk
    int unsigned starve_cnt;

    // Cycles with data held inside but nothing offered on the pop port
    always_ff @(posedge clk) begin
      if (rst || pop_valid[i] || pop_empty[i]) begin
        starve_cnt <= 0;
      end else begin
        starve_cnt <= starve_cnt + 1;
      end
    end

    pop_hold_chk: assert property (@(posedge clk) disable iff (rst)
      pop_valid[i] && !pop_ready[i] |=> pop_valid[i] && $stable(pop_data[i]))
      else begin
        assert_fails++;
        $error("pop port %0d changed while stalled", i);
      end

    progress_chk: assert property (@(posedge clk) disable iff (rst)
      starve_cnt < LIMIT)
      else begin
        assert_fails++;
        $error("FIFO %0d holds data but raised no pop_valid for %0d cycles", i, LIMIT);
      end
  end

endmodule

//--- verif/tb_clock_gen.sv
/*
  Clock and reset source for the testbench.
  Drives a 4 ns clock and holds rst high for the first two cycles.
  Raising rst_req asserts rst again for a later reset.
*/
`timescale 1ns/10ps

module tb_clock_gen (
  input  logic rst_req,
  output logic clk,
  output logic rst
);

  logic init_rst;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Power-on reset covers two rising edges
  initial begin
    init_rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    init_rst = 1'b0;
  end

  assign rst = init_rst || rst_req;

endmodule

//--- verif/tb_shared_fifo.sv
/*
  Testbench for the shared multi-FIFO.
  Pushes random traffic, keeps one reference queue per FIFO and checks
  every pop against it. Covers in-order delivery, bad configurations,
  back-pressure on one FIFO, random stalls and the final drain.
*/
`timescale 1ns/10ps
`include "shared_fifo_macros.svh"

module tb_shared_fifo
  import shared_fifo_pkg::*;
;

  localparam int NUM        = `SFIFO_NUM_FIFOS;
  localparam int REGION     = `SFIFO_DEPTH / `SFIFO_NUM_FIFOS;
  localparam int WAIT_LIMIT = 2000;
  localparam int LAYOUT_OK      = 0;
  localparam int LAYOUT_OVERLAP = 1;
  localparam int LAYOUT_INVERT  = 2;
  localparam int MODE_FREE   = 0;
  localparam int MODE_STALL  = 1;
  localparam int MODE_RANDOM = 2;

  logic                clk;
  logic                rst;
  logic                rst_req;
  addr_t  [NUM-1:0]    config_base;
  addr_t  [NUM-1:0]    config_bound;
  logic                config_error;
  logic                push_valid;
  logic                push_ready;
  data_t               push_data;
  fifo_id_t            push_fifo_id;
  logic   [NUM-1:0]    push_full;
  logic   [NUM-1:0]    pop_valid;
  logic   [NUM-1:0]    pop_ready;
  data_t  [NUM-1:0]    pop_data;
  logic   [NUM-1:0]    pop_empty;

  integer      seed = 32'hf6cfe707;
  data_t       ref_q [NUM][$];
  int          ready_mode [NUM] = '{default: MODE_FREE};
  int          errors = 0;
  int          err_base = 0;
  int unsigned asrt_seen = 0;
  int          passed = 0;
  int          failed = 0;

  bind shared_fifo_top shared_fifo_properties u_props (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_error(config_error), .push_valid(push_valid), .push_ready(push_ready),
    .push_fifo_id(push_fifo_id), .pop_valid(pop_valid), .pop_ready(pop_ready),
    .pop_data(pop_data), .pop_empty(pop_empty)
  );

  tb_clock_gen u_clkgen (.rst_req(rst_req), .clk(clk), .rst(rst));

  shared_fifo_top u_dut (
    .clk(clk), .rst(rst), .config_base(config_base), .config_bound(config_bound),
    .config_error(config_error), .push_valid(push_valid), .push_ready(push_ready),
    .push_data(push_data), .push_fifo_id(push_fifo_id), .push_full(push_full),
    .pop_valid(pop_valid), .pop_ready(pop_ready), .pop_data(pop_data),
    .pop_empty(pop_empty)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got == exp) else begin
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Handshakes are sampled at the falling edge, where all inputs are settled
  always @(negedge clk) begin : scoreboard
    data_t expected;
    if (rst) begin
      for (int i = 0; i < NUM; i++) ref_q[i].delete();
    end else begin
      if (push_valid && push_ready) ref_q[push_fifo_id].push_back(push_data);
      for (int i = 0; i < NUM; i++) begin
        if (pop_valid[i] && pop_ready[i]) begin
          if (ref_q[i].size() == 0) begin
            $display("%0t: FIFO %0d delivered an item that was never pushed", $time, i);
            errors++;
          end else begin
            expected = ref_q[i].pop_front();
            check_value($sformatf("pop_data[%0d]", i), expected, pop_data[i]);
          end
        end
      end
    end
  end

  // Pop side back-pressure, one pattern per FIFO
  initial begin
    pop_ready = '1;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < NUM; i++) begin
        case (ready_mode[i])
          MODE_STALL:  pop_ready[i] = 1'b0;
          MODE_RANDOM: pop_ready[i] = ($random(seed) & 3) != 0;
          default:     pop_ready[i] = 1'b1;
        endcase
      end
    end
  end

  task automatic set_layout(input int kind);
    for (int i = 0; i < NUM; i++) begin
      config_base[i]  = addr_t'(i * REGION);
      config_bound[i] = addr_t'(i * REGION + REGION - 1);
    end
    if (kind == LAYOUT_OVERLAP) begin
      config_base[1] = config_bound[0];
    end else if (kind == LAYOUT_INVERT) begin
      config_base[2]  = addr_t'(3 * REGION - 1);
      config_bound[2] = addr_t'(2 * REGION + 1);
    end
  endtask

  // New regions are loaded under reset, then one cycle lets config_error settle
  task automatic apply_config(input int kind);
    rst_req = 1'b1;
    set_layout(kind);
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    rst_req = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic push_item(input fifo_id_t id, input data_t d);
    int  cycles;
    bit  taken;
    cycles       = 0;
    taken        = 1'b0;
    push_valid   = 1'b1;
    push_fifo_id = id;
    push_data    = d;
    while (!taken && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      taken = push_ready && !rst;
      @(posedge clk);
      #1;
      cycles++;
    end
    push_valid = 1'b0;
    if (!taken) begin
      $display("%0t: push to FIFO %0d not accepted within %0d cycles", $time, id, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic random_traffic(input int count, input logic [NUM-1:0] allowed);
    fifo_id_t id;
    for (int n = 0; n < count; n++) begin
      id = fifo_id_t'($unsigned($random(seed)) % NUM);
      while (!allowed[id]) id = fifo_id_t'((int'(id) + 1) % NUM);
      push_item(id, data_t'($random(seed)));
    end
  endtask

  task automatic expect_refused(input fifo_id_t id, input string why);
    bit refused;
    refused      = 1'b1;
    push_valid   = 1'b1;
    push_fifo_id = id;
    push_data    = data_t'($random(seed));
    repeat (8) begin
      @(negedge clk);
      if (push_ready) refused = 1'b0;
      @(posedge clk);
      #1;
    end
    push_valid = 1'b0;
    if (!refused) begin
      $display("%0t: push to FIFO %0d accepted although %s", $time, id, why);
      errors++;
    end
  endtask

  task automatic wait_drain(input logic [NUM-1:0] mask, input string what);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      done = 1'b1;
      for (int i = 0; i < NUM; i++) begin
        if (mask[i] && (ref_q[i].size() != 0 || !pop_empty[i] || pop_valid[i])) done = 1'b0;
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("%0t: %s did not drain within %0d cycles", $time, what, WAIT_LIMIT);
      errors++;
    end
  endtask

  // Also folds in concurrent assertion failures seen during the test
  task automatic finish_test(input string name);
    int unsigned fails_now;
    fails_now = u_dut.u_props.assert_fails;
    if (fails_now != asrt_seen) begin
      $display("%0t: %0d concurrent check failures during %s", $time,
               fails_now - asrt_seen, name);
      errors += int'(fails_now - asrt_seen);
      asrt_seen = fails_now;
    end
    if (errors == err_base) begin
      $display("Test %s: pass", name);
      passed++;
    end else begin
      $display("Test %s: fail with %0d errors", name, errors - err_base);
      failed++;
    end
    err_base = errors;
  endtask

  initial begin
    rst_req      = 1'b0;
    push_valid   = 1'b0;
    push_data    = '0;
    push_fifo_id = '0;
    set_layout(LAYOUT_OK);
    @(posedge clk);
    #1;

    apply_config(LAYOUT_OK);
    random_traffic(40, '1);
    wait_drain('1, "random traffic");
    finish_test("in-order delivery");

    apply_config(LAYOUT_OVERLAP);
    @(negedge clk);
    check_value("config_error", 1, config_error);
    @(posedge clk);
    #1;
    expect_refused(0, "regions overlap");
    apply_config(LAYOUT_INVERT);
    @(negedge clk);
    check_value("config_error", 1, config_error);
    @(posedge clk);
    #1;
    expect_refused(2, "a base lies above its bound");
    apply_config(LAYOUT_OK);
    @(negedge clk);
    check_value("config_error", 0, config_error);
    @(posedge clk);
    #1;
    finish_test("configuration check");

    // FIFO 1 stalled: its region plus the staging buffer fills up
    ready_mode[1] = MODE_STALL;
    for (int n = 0; n < REGION + `SFIFO_STAGING_DEPTH; n++) begin
      push_item(1, data_t'($random(seed)));
    end
    @(negedge clk);
    check_value("push_full[1]", 1, push_full[1]);
    @(posedge clk);
    #1;
    expect_refused(1, "FIFO 1 is full");
    random_traffic(12, 4'b1101);
    wait_drain(4'b1101, "traffic around the stalled FIFO");
    ready_mode[1] = MODE_FREE;
    wait_drain('1, "released FIFO 1");
    finish_test("back-pressure");

    for (int i = 0; i < NUM; i++) ready_mode[i] = MODE_RANDOM;
    random_traffic(60, '1);
    wait_drain('1, "traffic under random stalls");
    for (int i = 0; i < NUM; i++) ready_mode[i] = MODE_FREE;
    finish_test("random stalls");

    wait_drain('1, "idle design");
    @(negedge clk);
    for (int i = 0; i < NUM; i++) begin
      check_value($sformatf("pop_empty[%0d]", i), 1, pop_empty[i]);
      check_value($sformatf("pop_valid[%0d]", i), 0, pop_valid[i]);
    end
    @(posedge clk);
    #1;
    finish_test("final drain");

    $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
